/* common/sha_pkg.sv */
// ######################################
// SHA-256 shared types
// ######################################
`default_nettype none

package sha_pkg;

  // word and state geometry
  localparam int WORD_W     = 32;
  localparam int HASH_WORDS = 8;   // a through h
  localparam int MAX_ROUNDS = 64;  // schedule words and constants
  localparam int ROUND_W    = 6;   // enough to index MAX_ROUNDS

  typedef logic [WORD_W-1:0] word_t;

  // index 0 is a, index 7 is h
  typedef word_t [0:HASH_WORDS-1] hash_state_t;

  // index 0 is w[0]
  typedef word_t [0:MAX_ROUNDS-1] msg_sched_t;

  typedef logic [ROUND_W-1:0] round_idx_t;

  // run control of the iterative core
  typedef enum logic {
    CTRL_IDLE,
    CTRL_RUN
  } ctrl_state_t;

  // rotate right by n bits, n in 1..WORD_W-1
  function automatic word_t rotr(input word_t x, input int unsigned n);
    return (x >> n) | (x << (WORD_W - n));
  endfunction

endpackage

`default_nettype wire

/* rtl/round_const_rom.sv */
// ######################################
// SHA-256 round constant table
// ######################################
`timescale 1ns/1ps
`default_nettype none

module round_const_rom (
  input  wire sha_pkg::round_idx_t round,
  output sha_pkg::word_t           k_t
);

  // cube roots of the first 64 primes, fractional part
  always_comb begin
    case (round)
      6'd0:  k_t = 32'h428a2f98;
      6'd1:  k_t = 32'h71374491;
      6'd2:  k_t = 32'hb5c0fbcf;
      6'd3:  k_t = 32'he9b5dba5;
      6'd4:  k_t = 32'h3956c25b;
      6'd5:  k_t = 32'h59f111f1;
      6'd6:  k_t = 32'h923f82a4;
      6'd7:  k_t = 32'hab1c5ed5;
      6'd8:  k_t = 32'hd807aa98;
      6'd9:  k_t = 32'h12835b01;
      6'd10: k_t = 32'h243185be;
      6'd11: k_t = 32'h550c7dc3;
      6'd12: k_t = 32'h72be5d74;
      6'd13: k_t = 32'h80deb1fe;
      6'd14: k_t = 32'h9bdc06a7;
      6'd15: k_t = 32'hc19bf174;
      6'd16: k_t = 32'he49b69c1;
      6'd17: k_t = 32'hefbe4786;
      6'd18: k_t = 32'h0fc19dc6;
      6'd19: k_t = 32'h240ca1cc;
      6'd20: k_t = 32'h2de92c6f;
      6'd21: k_t = 32'h4a7484aa;
      6'd22: k_t = 32'h5cb0a9dc;
      6'd23: k_t = 32'h76f988da;
      6'd24: k_t = 32'h983e5152;
      6'd25: k_t = 32'ha831c66d;
      6'd26: k_t = 32'hb00327c8;
      6'd27: k_t = 32'hbf597fc7;
      6'd28: k_t = 32'hc6e00bf3;
      6'd29: k_t = 32'hd5a79147;
      6'd30: k_t = 32'h06ca6351;
      6'd31: k_t = 32'h14292967;
      6'd32: k_t = 32'h27b70a85;
      6'd33: k_t = 32'h2e1b2138;
      6'd34: k_t = 32'h4d2c6dfc;
      6'd35: k_t = 32'h53380d13;
      6'd36: k_t = 32'h650a7354;
      6'd37: k_t = 32'h766a0abb;
      6'd38: k_t = 32'h81c2c92e;
      6'd39: k_t = 32'h92722c85;
      6'd40: k_t = 32'ha2bfe8a1;
      6'd41: k_t = 32'ha81a664b;
      6'd42: k_t = 32'hc24b8b70;
      6'd43: k_t = 32'hc76c51a3;
      6'd44: k_t = 32'hd192e819;
      6'd45: k_t = 32'hd6990624;
      6'd46: k_t = 32'hf40e3585;
      6'd47: k_t = 32'h106aa070;
      6'd48: k_t = 32'h19a4c116;
      6'd49: k_t = 32'h1e376c08;
      6'd50: k_t = 32'h2748774c;
      6'd51: k_t = 32'h34b0bcb5;
      6'd52: k_t = 32'h391c0cb3;
      6'd53: k_t = 32'h4ed8aa4a;
      6'd54: k_t = 32'h5b9cca4f;
      6'd55: k_t = 32'h682e6ff3;
      6'd56: k_t = 32'h748f82ee;
      6'd57: k_t = 32'h78a5636f;
      6'd58: k_t = 32'h84c87814;
      6'd59: k_t = 32'h8cc70208;
      6'd60: k_t = 32'h90befffa;
      6'd61: k_t = 32'ha4506ceb;
      6'd62: k_t = 32'hbef9a3f7;
      6'd63: k_t = 32'hc67178f2;
      default: k_t = 32'h428a2f98;  // unreachable, all 64 codes listed
    endcase
  end

endmodule

`default_nettype wire

/* comp_core/round_ctrl.sv */
// ######################################
// Round controller
// ######################################
`timescale 1ns/1ps
`default_nettype none

module round_ctrl #(
  parameter int ROUNDS = 64
) (
  input  wire                       clk,
  input  wire                       n_rst,
  input  wire                       comp_en,
  input  wire sha_pkg::msg_sched_t  w,
  output sha_pkg::round_idx_t       round,
  output sha_pkg::word_t            w_t,
  output logic                      load,
  output logic                      step
);

  localparam sha_pkg::round_idx_t LAST_ROUND = sha_pkg::round_idx_t'(ROUNDS - 1);

  sha_pkg::ctrl_state_t state;

  // comp_en only counts while idle
  assign load = (state == sha_pkg::CTRL_IDLE) && comp_en;
  assign step = load || (state == sha_pkg::CTRL_RUN);

  assign w_t = w[round];  // schedule word for this round

  always_ff @(posedge clk, negedge n_rst) begin
    if (!n_rst) begin
      state <= sha_pkg::CTRL_IDLE;
      round <= '0;
    end else begin
      case (state)
        sha_pkg::CTRL_IDLE: begin
          if (comp_en && ROUNDS > 1) begin  // round 0 is done on this edge
            state <= sha_pkg::CTRL_RUN;
            round <= sha_pkg::round_idx_t'(1);
          end
        end
        sha_pkg::CTRL_RUN: begin
          if (round == LAST_ROUND) begin
            state <= sha_pkg::CTRL_IDLE;
            round <= '0;
          end else begin
            round <= round + sha_pkg::round_idx_t'(1);
          end
        end
        default: begin
          state <= sha_pkg::CTRL_IDLE;
          round <= '0;
        end
      endcase
    end
  end

  // counter stays inside the configured run length
  assert property (@(posedge clk) disable iff (!n_rst)
    (state == sha_pkg::CTRL_RUN) |-> (round != '0 && int'(round) < ROUNDS));

  // a run opens only from idle, with the counter at rest
  assert property (@(posedge clk) disable iff (!n_rst)
    load |-> (round == '0));

endmodule

`default_nettype wire

/* comp_core/round_datapath.sv */
// ######################################
// SHA-256 round datapath
// ######################################
`timescale 1ns/1ps
`default_nettype none

module round_datapath (
  input  wire                         clk,
  input  wire                         n_rst,
  input  wire sha_pkg::hash_state_t   first_h,
  input  wire sha_pkg::word_t         w_t,
  input  wire sha_pkg::word_t         k_t,
  input  wire                         load,
  input  wire                         step,
  output sha_pkg::hash_state_t        h
);

  sha_pkg::hash_state_t cur;
  sha_pkg::hash_state_t nxt;
  sha_pkg::word_t       s1;
  sha_pkg::word_t       ch;
  sha_pkg::word_t       temp1;
  sha_pkg::word_t       s0;
  sha_pkg::word_t       maj;
  sha_pkg::word_t       temp2;

  // start of a run takes the seed words
  assign cur = load ? first_h : h;

  // e side
  assign s1 = sha_pkg::rotr(cur[4], 6) ^
              sha_pkg::rotr(cur[4], 11) ^
              sha_pkg::rotr(cur[4], 25);
  assign ch = (cur[4] & cur[5]) ^ (~cur[4] & cur[6]);
  assign temp1 = cur[7] + s1 + ch + k_t + w_t;

  // a side
  assign s0 = sha_pkg::rotr(cur[0], 2) ^
              sha_pkg::rotr(cur[0], 13) ^
              sha_pkg::rotr(cur[0], 22);
  assign maj = (cur[0] & cur[1]) ^ (cur[0] & cur[2]) ^ (cur[1] & cur[2]);
  assign temp2 = s0 + maj;

  always_comb begin
    nxt[0] = temp1 + temp2;
    nxt[1] = cur[0];
    nxt[2] = cur[1];
    nxt[3] = cur[2];
    nxt[4] = cur[3] + temp1;  // new e
    nxt[5] = cur[4];
    nxt[6] = cur[5];
    nxt[7] = cur[6];
  end

  always_ff @(posedge clk, negedge n_rst) begin
    if (!n_rst) begin
      h <= '0;
    end else if (step) begin
      h <= nxt;
    end
  end

  // a seed load always writes the register
  assert property (@(posedge clk) disable iff (!n_rst)
    load |-> step);

endmodule

`default_nettype wire

/* comp_core/miner_core_comp.sv */
// ######################################
// SHA-256 compression core
// ######################################
`timescale 1ns/1ps
`default_nettype none

module miner_core_comp #(
  parameter int ROUNDS = 64  // below 64 for reduced-round variants
) (
  input  wire                         clk,
  input  wire                         n_rst,
  input  wire                         comp_en,
  input  wire sha_pkg::msg_sched_t    w,
  input  wire sha_pkg::hash_state_t   first_h,
  output sha_pkg::hash_state_t        h
);

  sha_pkg::round_idx_t round;
  sha_pkg::word_t      w_t;
  sha_pkg::word_t      k_t;
  logic                load;
  logic                step;

  round_ctrl #(
    .ROUNDS (ROUNDS)
  ) u_ctrl (
    .clk     (clk),
    .n_rst   (n_rst),
    .comp_en (comp_en),
    .w       (w),
    .round   (round),
    .w_t     (w_t),
    .load    (load),
    .step    (step)
  );

  round_const_rom u_rom (
    .round (round),
    .k_t   (k_t)
  );

  round_datapath u_dp (
    .clk     (clk),
    .n_rst   (n_rst),
    .first_h (first_h),
    .w_t     (w_t),
    .k_t     (k_t),
    .load    (load),
    .step    (step),
    .h       (h)
  );

endmodule

`default_nettype wire

/* tb/tb_miner_core_comp.sv */
// ########################################
// Compression core testbench
// ########################################
`timescale 1ns/1ps
`default_nettype none

module tb_miner_core_comp;

  localparam int ROUNDS      = 64;
  localparam int CLK_PERIOD  = 4;
  localparam int RST_CYCLES  = 5;
  localparam int HOLD_CYCLES = 10;
  localparam int N_VEC       = 7;

  typedef enum logic [1:0] {
    W_ABC,
    W_ZERO,
    W_RAND
  } w_src_t;

  typedef struct packed {
    logic   rand_h;        // 0 takes the standard IV
    w_src_t w_src;
    logic   mid_pulse;     // extra comp_en in the middle of the run
    logic   back_to_back;  // comp_en held high over two runs
  } vec_t;

  localparam vec_t VEC_TAB [N_VEC] = '{
    '{1'b0, W_ABC,  1'b0, 1'b0},
    '{1'b0, W_ZERO, 1'b0, 1'b0},
    '{1'b1, W_RAND, 1'b0, 1'b0},
    '{1'b1, W_RAND, 1'b0, 1'b0},
    '{1'b0, W_ABC,  1'b1, 1'b0},
    '{1'b1, W_RAND, 1'b1, 1'b0},
    '{1'b0, W_ABC,  1'b0, 1'b1}
  };

  localparam sha_pkg::hash_state_t IV = {
    32'h6a09e667, 32'hbb67ae85, 32'h3c6ef372, 32'ha54ff53a,
    32'h510e527f, 32'h9b05688c, 32'h1f83d9ab, 32'h5be0cd19
  };

  // sha-256 of "abc"
  localparam sha_pkg::hash_state_t DIGEST_ABC = {
    32'hba7816bf, 32'h8f01cfea, 32'h414140de, 32'h5dae2223,
    32'hb00361a3, 32'h96177a9c, 32'hb410ff61, 32'hf20015ad
  };

  logic                 clk;
  logic                 n_rst;
  logic                 comp_en;
  sha_pkg::msg_sched_t  w;
  sha_pkg::hash_state_t first_h;
  sha_pkg::hash_state_t h;

  sha_pkg::round_idx_t  k_idx;
  sha_pkg::word_t       k_ref_out;
  logic [31:0]          k_tab [sha_pkg::MAX_ROUNDS];

  miner_core_comp #(
    .ROUNDS (ROUNDS)
  ) dut (
    .clk     (clk),
    .n_rst   (n_rst),
    .comp_en (comp_en),
    .w       (w),
    .first_h (first_h),
    .h       (h)
  );

  // separate copy of the constant table for the model
  round_const_rom k_ref (
    .round (k_idx),
    .k_t   (k_ref_out)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic logic [31:0] ror(input logic [31:0] x, input int n);
    return (x >> n) | (x << (32 - n));
  endfunction

  // ROUNDS rounds of the compression function, no feed-forward
  function automatic sha_pkg::hash_state_t model_rounds(
    input sha_pkg::hash_state_t init,
    input sha_pkg::msg_sched_t  ws
  );
    sha_pkg::hash_state_t v;
    logic [31:0]          t1;
    logic [31:0]          t2;
    v = init;
    for (int r = 0; r < ROUNDS; r++) begin
      t1 = v[7] + (ror(v[4], 6) ^ ror(v[4], 11) ^ ror(v[4], 25)) +
           ((v[4] & v[5]) ^ (~v[4] & v[6])) + k_tab[r] + ws[r];
      t2 = (ror(v[0], 2) ^ ror(v[0], 13) ^ ror(v[0], 22)) +
           ((v[0] & v[1]) ^ (v[0] & v[2]) ^ (v[1] & v[2]));
      v = {t1 + t2, v[0], v[1], v[2], v[3] + t1, v[4], v[5], v[6]};
    end
    return v;
  endfunction

  // padded single block for "abc", expanded to 64 words
  function automatic sha_pkg::msg_sched_t abc_schedule();
    sha_pkg::msg_sched_t s;
    logic [31:0]         sg0;
    logic [31:0]         sg1;
    s = '0;
    s[0] = 32'h61626380;
    s[15] = 32'h00000018;  // message length in bits
    for (int t = 16; t < 64; t++) begin
      sg0 = ror(s[t-15], 7) ^ ror(s[t-15], 18) ^ (s[t-15] >> 3);
      sg1 = ror(s[t-2], 17) ^ ror(s[t-2], 19) ^ (s[t-2] >> 10);
      s[t] = sg1 + s[t-7] + sg0 + s[t-16];
    end
    return s;
  endfunction

  function automatic sha_pkg::hash_state_t rand_state();
    sha_pkg::hash_state_t s;
    for (int i = 0; i < sha_pkg::HASH_WORDS; i++) begin
      s[i] = $urandom();
    end
    return s;
  endfunction

  function automatic sha_pkg::msg_sched_t make_sched(input w_src_t src);
    sha_pkg::msg_sched_t s;
    case (src)
      W_ABC:   s = abc_schedule();
      W_ZERO:  s = '0;
      default: begin
        for (int i = 0; i < sha_pkg::MAX_ROUNDS; i++) begin
          s[i] = $urandom();
        end
      end
    endcase
    return s;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp);
      $display("TB FAILED");
      $fatal(1, "value mismatch on %s", name);
    end
  endtask

  task automatic check_state(input string what, input sha_pkg::hash_state_t got,
                             input sha_pkg::hash_state_t exp);
    for (int i = 0; i < sha_pkg::HASH_WORDS; i++) begin
      check_value($sformatf("h[%0d] (%s)", i, what), got[i], exp[i]);
    end
  endtask

  task automatic sweep_k_table();
    for (int i = 0; i < sha_pkg::MAX_ROUNDS; i++) begin
      k_idx = sha_pkg::round_idx_t'(i);
      #0.25;
      k_tab[i] = k_ref_out;
    end
  endtask

  // starts and ends on a falling edge
  task automatic run_entry(input int idx);
    vec_t                 v;
    sha_pkg::hash_state_t exp_h;
    sha_pkg::hash_state_t digest_diff;
    string                tag;
    v = VEC_TAB[idx];
    tag = $sformatf("entry %0d", idx);
    first_h = v.rand_h ? rand_state() : IV;
    w = make_sched(v.w_src);
    exp_h = model_rounds(first_h, w);
    comp_en = 1'b1;
    @(negedge clk);  // round 0 done on the start edge
    if (!v.back_to_back) begin
      comp_en = 1'b0;
    end
    for (int c = 1; c < ROUNDS; c++) begin
      @(negedge clk);
      if (!v.back_to_back) begin
        comp_en = v.mid_pulse && (c == ROUNDS / 2);
      end
    end
    check_state(tag, h, exp_h);
    if (!v.rand_h && v.w_src == W_ABC && ROUNDS == 64) begin
      for (int i = 0; i < sha_pkg::HASH_WORDS; i++) begin
        digest_diff[i] = DIGEST_ABC[i] - IV[i];
      end
      check_state({tag, " abc digest"}, h, digest_diff);
    end
    if (v.back_to_back) begin
      // second run loads on the next edge
      first_h = rand_state();
      w = make_sched(W_RAND);
      exp_h = model_rounds(first_h, w);
      repeat (ROUNDS) @(negedge clk);
      comp_en = 1'b0;
      check_state({tag, " second run"}, h, exp_h);
    end
    repeat (HOLD_CYCLES) begin
      @(negedge clk);
      check_state({tag, " hold"}, h, exp_h);
    end
  endtask

  initial begin
    int unsigned seed_ret;
    n_rst = 1'b0;
    comp_en = 1'b0;
    w = '0;
    first_h = '0;
    k_idx = '0;
    seed_ret = $urandom(32'hbc3f);
    fork
      sweep_k_table();
      repeat (RST_CYCLES) @(negedge clk);
    join
    n_rst = 1'b1;
    check_state("after reset", h, '0);
    repeat (3) @(negedge clk);
    check_state("idle before start", h, '0);
    for (int i = 0; i < N_VEC; i++) begin
      run_entry(i);
    end
    $display("TB PASSED");
    $finish;
  end

  // watchdog
  initial begin
    int wd_cycles;
    wd_cycles = RST_CYCLES + 4;
    for (int i = 0; i < N_VEC; i++) begin
      wd_cycles += (VEC_TAB[i].back_to_back ? 2 : 1) * (ROUNDS + 20);
    end
    #(wd_cycles * CLK_PERIOD);
    $display("timeout: the test sequence did not complete in %0d cycles", wd_cycles);
    $display("TB FAILED");
    $fatal(1, "watchdog expired");
  end

endmodule

`default_nettype wire

/* miner_core_comp.f */
common/sha_pkg.sv
rtl/round_const_rom.sv
comp_core/round_ctrl.sv
comp_core/round_datapath.sv
comp_core/miner_core_comp.sv
tb/tb_miner_core_comp.sv

/* run_sim.sh */
#!/bin/sh
# Builds the compression core testbench with Verilator and runs it.
# The run counts as passed only if the simulation prints the pass line.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert \
    --top-module tb_miner_core_comp \
    -f miner_core_comp.f \
    --Mdir obj_dir -o sim_tb; then
  echo "verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/sim_tb)
sim_status=$?
printf '%s\n' "$sim_out"

if [ "$sim_status" -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "TB PASSED"; then
  exit 0
else
  echo "pass line not found in simulation output"
  exit 1
fi
